/* common/dll_code_pkg.sv */
// delay code is plain binary, coarse field above fine field; loop state encoding is fixed at 2 bits
`default_nettype none

package dll_code_pkg;

  // ------------------------------
  // code layout
  // ------------------------------
  localparam int code_w   = 11;  // full delay code
  localparam int coarse_w = 8;   // upper field, one unit per delay cell
  localparam int fine_w   = 3;   // lower field, interpolator setting

  // one delay code, {coarse, fine}
  typedef logic [code_w-1:0] dll_code_t;

  // a coarse step moves one whole coarse unit
  localparam int coarse_step = 8;

  // ------------------------------
  // loop state
  // ------------------------------
  // also visible in the status register, bits 2:1
  typedef enum logic [1:0] {
    idle          = 2'd0,  // loop off, code held
    coarse_search = 2'd1,  // big steps toward the edge
    fine_track    = 2'd2,  // unit steps, counting reversals
    locked        = 2'd3   // lock raised, still tracking
  } dll_state_t;

endpackage

`default_nettype wire

/* common/dll_csr_pkg.sv */
// word addressed register map, 16-bit data; only the bits named here carry meaning
`default_nettype none

package dll_csr_pkg;

  localparam int csr_data_w = 16;  // wishbone data width

  // ------------------------------
  // word addresses
  // ------------------------------
  typedef enum logic [1:0] {
    ctrl       = 2'd0,  // rw
    start_code = 2'd1,  // rw, code loaded on enable
    status     = 2'd2,  // ro
    cur_code   = 2'd3   // ro, live full code
  } csr_addr_t;

  // ctrl bits
  localparam int ctrl_enable_bit   = 0;  // run the loop
  localparam int ctrl_half_sel_bit = 1;  // output half-cycle code

  // status bits
  localparam int status_lock_bit  = 0;
  localparam int status_state_lsb = 1;  // loop state in bits 2:1

endpackage

`default_nettype wire

/* dll_ctrl/dll_phase_filter.sv */
// filter_len must stay in 2..15; phase_late is taken as already synchronous to clk
`default_nettype none
`timescale 1ns/1ns

module dll_phase_filter #(
  parameter int filter_len = 4  // agreeing samples per step
) (
  input  logic clk,
  input  logic reset_n,
  input  logic enable,
  input  logic phase_late,  // 1 = delayed clock late
  output logic step_up,     // one-cycle pulse
  output logic step_down    // one-cycle pulse
);

  logic       dir_q;     // direction of the current run
  logic [3:0] cnt_q;     // agreeing samples so far
  logic [3:0] cnt_next;
  logic       agree;
  logic       hit;       // run complete this sample

  assign agree    = (phase_late == dir_q);
  // opposite sample starts a new run of length 1
  assign cnt_next = agree ? cnt_q + 4'd1 : 4'd1;
  assign hit      = (cnt_next == 4'(filter_len));

  // ------------------------------
  // run counter and step pulses
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dir_q     <= 1'b0;
      cnt_q     <= '0;
      step_up   <= 1'b0;
      step_down <= 1'b0;
    end else if (!enable) begin
      cnt_q     <= '0;  // loop off, forget partial run
      step_up   <= 1'b0;
      step_down <= 1'b0;
    end else begin
      dir_q     <= phase_late;             // follows the sample, unchanged on agree
      cnt_q     <= hit ? '0 : cnt_next;    // restart after each step
      step_up   <= hit && phase_late;
      step_down <= hit && !phase_late;     // never both high
    end
  end

endmodule

`default_nettype wire

/* dll_ctrl/dll_lock_fsm.sv */
// step pulses must be one cycle wide and never both high; code saturates at 0 and 2047
`default_nettype none
`timescale 1ns/1ns

module dll_lock_fsm #(
  parameter int lock_reversals = 2  // fine reversals before lock
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    enable,
  input  dll_code_pkg::dll_code_t start_code,
  input  logic                    step_up,
  input  logic                    step_down,
  output dll_code_pkg::dll_code_t pvt_ref_binary,  // full delay code
  output dll_code_pkg::dll_state_t loop_state,
  output logic                    lock
);

  import dll_code_pkg::*;

  dll_state_t state_q;
  dll_code_t  code_q;
  logic       en_q;         // enable last cycle, for rising edge
  logic       dir_q;        // direction of last step, 1 = up
  logic       dir_valid_q;  // a step has been taken since enable
  logic [3:0] rev_cnt_q;    // reversals seen in fine_track
  logic [3:0] rev_next;
  logic       step;
  logic       reversal;

  // saturating add or subtract of amt
  function automatic dll_code_t next_code(input dll_code_t cur, input logic up,
                                          input dll_code_t amt);
    logic [code_w:0] wide;
    if (up) begin
      wide = {1'b0, cur} + {1'b0, amt};
      next_code = wide[code_w] ? '1 : wide[code_w-1:0];  // clamp at 2047
    end else begin
      wide = '0;
      next_code = (cur < amt) ? '0 : cur - amt;           // clamp at 0
    end
  endfunction

  assign step     = step_up || step_down;
  assign reversal = dir_valid_q && (step_up != dir_q);
  assign rev_next = rev_cnt_q + 4'd1;

  // ------------------------------
  // state and code
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q     <= idle;
      code_q      <= '0;
      en_q        <= 1'b0;
      dir_q       <= 1'b0;
      dir_valid_q <= 1'b0;
      rev_cnt_q   <= '0;
    end else begin
      en_q <= enable;
      if (!enable) begin
        state_q <= idle;  // code held as is
      end else if (!en_q) begin
        // rising enable, restart search from start_code
        state_q     <= coarse_search;
        code_q      <= start_code;
        dir_valid_q <= 1'b0;
        rev_cnt_q   <= '0;
      end else if (step) begin
        dir_q       <= step_up;
        dir_valid_q <= 1'b1;
        case (state_q)
          coarse_search: begin
            if (reversal) begin
              state_q <= fine_track;  // overshot, switch to unit steps
              code_q  <= next_code(code_q, step_up, dll_code_t'(1));
            end else begin
              code_q <= next_code(code_q, step_up, dll_code_t'(coarse_step));
            end
          end
          fine_track: begin
            code_q <= next_code(code_q, step_up, dll_code_t'(1));
            if (reversal) begin
              rev_cnt_q <= rev_next;
              if (rev_next >= 4'(lock_reversals)) state_q <= locked;
            end
          end
          locked: code_q <= next_code(code_q, step_up, dll_code_t'(1));  // keep tracking
          default: state_q <= idle;  // idle is left only by rising enable
        endcase
      end
    end
  end

  assign pvt_ref_binary = code_q;
  assign loop_state     = state_q;
  assign lock           = (state_q == locked);  // low again as soon as enable drops

endmodule

`default_nettype wire

/* logic/half_cycle_code_gen.sv */
// half code is an approximation, fine field capped at 7; no glitch protection when the code changes
`default_nettype none
`timescale 1ns/1ns

module half_cycle_code_gen (
  input  logic                    clk,
  input  logic                    reset_n,
  input  dll_code_pkg::dll_code_t pvt_ref_binary,      // full-period code
  input  logic                    half_sel,            // 1 = drive half code
  output dll_code_pkg::dll_code_t pvt_ref_half_binary  // code to the delay chain
);

  import dll_code_pkg::*;

  localparam logic [fine_w:0] fine_half = 1 << (fine_w - 1);  // half a coarse unit
  localparam logic [fine_w:0] fine_max  = (1 << fine_w) - 1;

  logic [coarse_w-1:0] coarse_in;
  logic [fine_w-1:0]   fine_in;
  logic [coarse_w-1:0] half_coarse;
  logic [fine_w:0]     fine_sum;   // one spare bit before the cap
  logic [fine_w-1:0]   half_fine;

  assign coarse_in = pvt_ref_binary[code_w-1:fine_w];
  assign fine_in   = pvt_ref_binary[fine_w-1:0];

  // ------------------------------
  // halve coarse and fine
  // ------------------------------
  assign half_coarse = coarse_in >> 1;
  // odd coarse leaves half a unit, rounded fine added on top
  assign fine_sum    = (coarse_in[0] ? fine_half : '0)
                     + {1'b0, fine_in >> 1}
                     + {{fine_w{1'b0}}, fine_in[0]};
  assign half_fine   = (fine_sum > fine_max) ? fine_max[fine_w-1:0] : fine_sum[fine_w-1:0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pvt_ref_half_binary <= '0;
    end else begin
      pvt_ref_half_binary <= half_sel ? {half_coarse, half_fine} : pvt_ref_binary;
    end
  end

endmodule

`default_nettype wire

/* logic/dll_csr_wb.sv */
// wishbone classic, single ack per transfer, no wait states and no err/rty; unused data bits read 0
`default_nettype none
`timescale 1ns/1ns

module dll_csr_wb (
  input  logic                                clk,
  input  logic                                reset_n,
  // wishbone slave
  input  logic                                cyc,
  input  logic                                stb,
  input  logic                                we,
  input  dll_csr_pkg::csr_addr_t              adr,
  input  logic [dll_csr_pkg::csr_data_w-1:0]  dat_w,
  output logic [dll_csr_pkg::csr_data_w-1:0]  dat_r,
  output logic                                ack,
  // loop side
  input  logic                                lock,
  input  dll_code_pkg::dll_state_t            loop_state,
  input  dll_code_pkg::dll_code_t             cur_code,
  output logic                                enable,
  output logic                                half_sel,
  output dll_code_pkg::dll_code_t             start_code
);

  import dll_code_pkg::*;
  import dll_csr_pkg::*;

  logic                  ctrl_enable_q;
  logic                  ctrl_half_sel_q;
  dll_code_t             start_code_q;
  logic [csr_data_w-1:0] rd_data;
  logic                  req;  // new transfer seen this cycle

  // ack low in between keeps a held stb to one ack per transfer
  assign req = cyc && stb && !ack;

  // ------------------------------
  // ack
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  // ------------------------------
  // writable registers
  // ------------------------------
  // write lands on the same edge that raises ack
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl_enable_q   <= 1'b0;
      ctrl_half_sel_q <= 1'b0;
      start_code_q    <= '0;
    end else if (req && we) begin
      case (adr)
        dll_csr_pkg::ctrl: begin
          ctrl_enable_q   <= dat_w[ctrl_enable_bit];
          ctrl_half_sel_q <= dat_w[ctrl_half_sel_bit];
        end
        dll_csr_pkg::start_code: start_code_q <= dat_w[code_w-1:0];
        default: ;  // status and cur_code ignore writes
      endcase
    end
  end

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb begin
    rd_data = '0;
    case (adr)
      dll_csr_pkg::ctrl: begin
        rd_data[ctrl_enable_bit]   = ctrl_enable_q;
        rd_data[ctrl_half_sel_bit] = ctrl_half_sel_q;
      end
      dll_csr_pkg::start_code: rd_data[code_w-1:0] = start_code_q;
      dll_csr_pkg::status: begin
        rd_data[status_lock_bit]                           = lock;        // live
        rd_data[status_state_lsb +: $bits(dll_state_t)]    = loop_state;  // live
      end
      default: rd_data[code_w-1:0] = cur_code;  // live full code
    endcase
  end

  // captured with the request, valid while ack is high
  always_ff @(posedge clk) begin
    if (req) dat_r <= rd_data;
  end

  assign enable     = ctrl_enable_q;
  assign half_sel   = ctrl_half_sel_q;
  assign start_code = start_code_q;

endmodule

`default_nettype wire

/* logic/dll_code_top.sv */
// phase_late must be synchronous to clk; dll_code follows the full code one clock later
`default_nettype none
`timescale 1ns/1ns

module dll_code_top #(
  parameter int filter_len     = 4,  // 2..15
  parameter int lock_reversals = 2
) (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               phase_late,  // from phase detector
  // wishbone
  input  logic                               cyc,
  input  logic                               stb,
  input  logic                               we,
  input  dll_csr_pkg::csr_addr_t             adr,
  input  logic [dll_csr_pkg::csr_data_w-1:0] dat_w,
  output logic [dll_csr_pkg::csr_data_w-1:0] dat_r,
  output logic                               ack,
  // to delay chain
  output dll_code_pkg::dll_code_t            dll_code,
  output logic                               lock
);

  import dll_code_pkg::*;

  logic       enable;
  logic       half_sel;
  dll_code_t  start_code;
  logic       step_up;
  logic       step_down;
  dll_code_t  pvt_ref_binary;  // full code from the loop
  dll_state_t loop_state;

  // ------------------------------
  // register bank
  // ------------------------------
  dll_csr_wb dll_csr_wb_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .lock       (lock),
    .loop_state (loop_state),
    .cur_code   (pvt_ref_binary),
    .enable     (enable),
    .half_sel   (half_sel),
    .start_code (start_code)
  );

  // ------------------------------
  // loop chain
  // ------------------------------
  dll_phase_filter #(
    .filter_len (filter_len)
  ) dll_phase_filter_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .enable     (enable),
    .phase_late (phase_late),
    .step_up    (step_up),
    .step_down  (step_down)
  );

  dll_lock_fsm #(
    .lock_reversals (lock_reversals)
  ) dll_lock_fsm_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .enable         (enable),
    .start_code     (start_code),
    .step_up        (step_up),
    .step_down      (step_down),
    .pvt_ref_binary (pvt_ref_binary),
    .loop_state     (loop_state),
    .lock           (lock)
  );

  half_cycle_code_gen half_cycle_code_gen_inst (
    .clk                 (clk),
    .reset_n             (reset_n),
    .pvt_ref_binary      (pvt_ref_binary),
    .half_sel            (half_sel),
    .pvt_ref_half_binary (dll_code)  // registered output code
  );

endmodule

`default_nettype wire

/* tb/dll_code_model.svh */
// expects dll_code_pkg and dll_csr_pkg imported by the including module; target above 2047 is always late
`ifndef DLL_CODE_MODEL_SVH
`define DLL_CODE_MODEL_SVH

// ------------------------------
// phase detector
// ------------------------------
// delayed clock arrives late while the full code sits below the target
function automatic logic late_for(input dll_code_t code, input int tgt);
  return int'(code) < tgt;
endfunction

// a locked loop dithers between tgt-1 and tgt, floor at 0
function automatic logic in_lock_window(input dll_code_t code, input int tgt);
  int lo;
  lo = (tgt > 0) ? tgt - 1 : 0;
  return (int'(code) >= lo) && (int'(code) <= tgt);
endfunction

// ------------------------------
// half-cycle rule
// ------------------------------
function automatic dll_code_t half_code(input dll_code_t code);
  int coarse;
  int fine;
  int hfine;
  coarse = int'(code) / 8;  // 3 fine bits below coarse
  fine   = int'(code) % 8;
  hfine  = fine / 2 + fine % 2;             // halved fine, rounded up
  if (coarse % 2 == 1) hfine = hfine + 4;   // odd coarse leaves half a cell
  if (hfine > 7) hfine = 7;                 // cap
  return dll_code_t'((coarse / 2) * 8 + hfine);
endfunction

// ------------------------------
// register map
// ------------------------------
function automatic logic [csr_data_w-1:0] ctrl_word(input logic en, input logic half);
  logic [csr_data_w-1:0] w;
  w                    = '0;
  w[ctrl_enable_bit]   = en;
  w[ctrl_half_sel_bit] = half;
  return w;
endfunction

function automatic dll_state_t status_state(input logic [csr_data_w-1:0] rd);
  return dll_state_t'(rd[status_state_lsb +: 2]);  // state in bits 2:1
endfunction

function automatic logic status_lock(input logic [csr_data_w-1:0] rd);
  return rd[status_lock_bit];
endfunction

`endif

/* tb/dll_code_tb.sv */
// runs the DUT with default filter_len 4 and lock_reversals 2; phase detector is modeled in the testbench
`default_nettype none
`timescale 1ns/1ns

module dll_code_tb;

  import dll_code_pkg::*;
  import dll_csr_pkg::*;

  localparam int filter_len   = 4;
  localparam int clk_period   = 20;
  localparam int drive_dly    = 2;   // inputs change this long after the rising edge
  localparam int trial_cycles = (2048 / 8 + 64) * filter_len * 2;
  localparam int cycle_limit  = 20 * trial_cycles;
  localparam int pl_model     = 0;   // late while code below target
  localparam int pl_alt       = 1;   // runs shorter than filter_len
  localparam int pl_level     = 2;   // constant level

  logic                  clk;
  logic                  reset_n;
  logic                  phase_late;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  csr_addr_t             adr;
  logic [csr_data_w-1:0] dat_w;
  logic [csr_data_w-1:0] dat_r;
  logic                  ack;
  dll_code_t             dll_code;
  logic                  lock;
  int                    pl_mode;
  int                    target;      // model target code
  logic                  level_val;   // phase_late in pl_level mode
  int                    run_left;    // samples left in the current alternating run
  int                    cycle_cnt;

  `include "dll_code_model.svh"

  dll_code_top #(
    .filter_len     (filter_len),
    .lock_reversals (2)
  ) dll_code_top_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .phase_late (phase_late),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .dll_code   (dll_code),
    .lock       (lock)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ------------------------------
  // phase detector and timeout
  // ------------------------------
  always @(posedge clk) begin
    #(drive_dly);
    case (pl_mode)
      pl_model: phase_late = late_for(dll_code, target);  // valid with half_sel low
      pl_alt: begin
        if (run_left == 0) begin
          phase_late = ~phase_late;
          run_left   = $urandom_range(filter_len - 1, 1) - 1;
        end else begin
          run_left = run_left - 1;
        end
      end
      default: phase_late = level_val;
    endcase
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) fail_run("timeout: cycle limit reached before the tests ended");
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_code(input string what, input dll_code_t got, input dll_code_t exp);
    if (got !== exp)
      fail_run($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic compare_state(input string what, input dll_state_t got, input dll_state_t exp);
    if (got !== exp)
      fail_run($sformatf("error at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                         exp.name()));
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // ------------------------------
  // wishbone master
  // ------------------------------
  task automatic bus_transfer(input logic write, input csr_addr_t addr,
                              input logic [csr_data_w-1:0] wdata,
                              output logic [csr_data_w-1:0] rdata, output dll_code_t out_code);
    @(posedge clk);
    #(drive_dly);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = addr;
    dat_w = wdata;
    @(posedge clk);
    #(drive_dly);
    compare_bit("ack one cycle after request", ack, 1'b1);  // no wait states
    rdata    = dat_r;
    out_code = dll_code;  // registered on the same edge as dat_r
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    @(posedge clk);
    #(drive_dly);
    compare_bit("ack after transfer", ack, 1'b0);  // exactly one ack
  endtask

  task automatic write_reg(input csr_addr_t addr, input logic [csr_data_w-1:0] wdata);
    logic [csr_data_w-1:0] rd;
    dll_code_t             out;
    bus_transfer(1'b1, addr, wdata, rd, out);
  endtask

  task automatic read_reg(input csr_addr_t addr, output logic [csr_data_w-1:0] rd);
    dll_code_t out;
    bus_transfer(1'b0, addr, '0, rd, out);
  endtask

  task automatic read_code(output dll_code_t code, output dll_code_t out);
    logic [csr_data_w-1:0] rd;
    bus_transfer(1'b0, dll_csr_pkg::cur_code, '0, rd, out);
    code = rd[code_w-1:0];
  endtask

  // loop off, new start code and stimulus, loop on again
  task automatic restart_loop(input dll_code_t start, input logic half, input int mode);
    write_reg(dll_csr_pkg::ctrl, ctrl_word(1'b0, 1'b0));
    write_reg(dll_csr_pkg::start_code, csr_data_w'(start));
    pl_mode  = mode;  // enable low, so the switch moves nothing
    run_left = 0;
    write_reg(dll_csr_pkg::ctrl, ctrl_word(1'b1, half));
  endtask

  task automatic wait_for_code(input dll_code_t exp);
    int waited;
    waited = 0;
    while (dll_code !== exp) begin
      @(posedge clk);
      #(drive_dly);
      waited++;
      if (waited > trial_cycles)
        fail_run($sformatf("dll_code did not reach %0d within %0d cycles", exp, trial_cycles));
    end
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task automatic register_access();
    logic [csr_data_w-1:0] rd;
    logic [csr_data_w-1:0] wr;
    dll_code_t             held;
    dll_code_t             code;
    dll_code_t             out;
    read_reg(dll_csr_pkg::status, rd);
    compare_state("state after reset", status_state(rd), idle);
    compare_bit("status lock after reset", status_lock(rd), 1'b0);
    repeat (8) begin
      wr = csr_data_w'($urandom);  // upper bits are not stored
      write_reg(dll_csr_pkg::ctrl, wr);
      read_reg(dll_csr_pkg::ctrl, rd);
      compare_bit("ctrl enable readback", rd[ctrl_enable_bit], wr[ctrl_enable_bit]);
      compare_bit("ctrl half_sel readback", rd[ctrl_half_sel_bit], wr[ctrl_half_sel_bit]);
      wr = csr_data_w'($urandom);
      write_reg(dll_csr_pkg::start_code, wr);
      read_reg(dll_csr_pkg::start_code, rd);
      compare_code("start_code readback", rd[code_w-1:0], wr[code_w-1:0]);
    end
    write_reg(dll_csr_pkg::ctrl, ctrl_word(1'b0, 1'b0));
    read_code(held, out);
    write_reg(dll_csr_pkg::status, csr_data_w'($urandom));    // read-only, ignored
    write_reg(dll_csr_pkg::cur_code, csr_data_w'($urandom));
    read_reg(dll_csr_pkg::status, rd);
    compare_state("state after read-only writes", status_state(rd), idle);
    read_code(code, out);
    compare_code("code after read-only writes", code, held);
  endtask

  task automatic filter_rejects_noise(input int trials);
    dll_code_t start;
    dll_code_t code;
    dll_code_t out;
    repeat (trials) begin
      start = dll_code_t'($urandom);
      restart_loop(start, 1'b0, pl_alt);
      read_code(code, out);
      compare_code("code under short phase runs", code, start);
      repeat (200) @(posedge clk);
      read_code(code, out);
      compare_code("code after 200 noisy samples", code, start);
    end
  endtask

  task automatic half_code_output(input int trials);
    dll_code_t code;
    dll_code_t out;
    repeat (trials) begin
      level_val = $urandom_range(1, 0);  // code walks up or down
      restart_loop(dll_code_t'($urandom), 1'b1, pl_level);
      repeat (16) begin
        read_code(code, out);
        compare_code("dll_code with half_sel set", out, half_code(code));
      end
      write_reg(dll_csr_pkg::ctrl, ctrl_word(1'b1, 1'b0));
      repeat (8) begin
        read_code(code, out);
        compare_code("dll_code with half_sel clear", out, code);
      end
    end
  endtask

  task automatic acquire_and_disable(input int trials);
    logic [csr_data_w-1:0] rd;
    dll_code_t             start;
    dll_code_t             code;
    dll_code_t             held;
    dll_code_t             out;
    int                    waited;
    repeat (trials) begin
      target = $urandom_range(2047, 1);
      restart_loop(dll_code_t'($urandom), 1'b0, pl_model);
      waited = 0;
      while (!lock) begin
        @(posedge clk);
        #(drive_dly);
        waited++;
        if (waited > trial_cycles)
          fail_run($sformatf("lock did not rise for target %0d within %0d cycles", target,
                             trial_cycles));
      end
      repeat (6) begin
        read_code(code, out);
        compare_bit($sformatf("code %0d within one below target %0d", code, target),
                    in_lock_window(code, target), 1'b1);
        compare_bit("lock while tracking", lock, 1'b1);
      end
      write_reg(dll_csr_pkg::ctrl, ctrl_word(1'b0, 1'b0));
      compare_bit("lock after disable", lock, 1'b0);
      read_reg(dll_csr_pkg::status, rd);
      compare_state("state after disable", status_state(rd), idle);
      compare_bit("status lock after disable", status_lock(rd), 1'b0);
      read_code(held, out);
      repeat (20) @(posedge clk);
      read_code(code, out);
      compare_code("code held while disabled", code, held);
      start = dll_code_t'($urandom);  // re-enable with noise only, no steps
      restart_loop(start, 1'b0, pl_alt);
      read_code(code, out);
      compare_code("code after enable again", code, start);
      read_reg(dll_csr_pkg::status, rd);
      compare_state("state after enable again", status_state(rd), coarse_search);
    end
  endtask

  task automatic saturate_code();
    dll_code_t code;
    dll_code_t out;
    target = 4096;  // always late
    restart_loop(dll_code_t'($urandom), 1'b0, pl_model);
    wait_for_code(dll_code_t'(2047));
    repeat (40) @(posedge clk);
    read_code(code, out);
    compare_code("code at ceiling", code, dll_code_t'(2047));
    compare_code("dll_code at ceiling", out, dll_code_t'(2047));
    target = 0;  // never late
    restart_loop(dll_code_t'($urandom), 1'b0, pl_model);
    wait_for_code(dll_code_t'(0));
    repeat (40) @(posedge clk);
    read_code(code, out);
    compare_code("code at floor", code, dll_code_t'(0));
    compare_code("dll_code at floor", out, dll_code_t'(0));
  endtask

  initial begin
    void'($urandom(32'h053585d7));
    reset_n    = 1'b0;
    phase_late = 1'b0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = dll_csr_pkg::ctrl;
    dat_w      = '0;
    pl_mode    = pl_level;
    level_val  = 1'b0;
    target     = 0;
    run_left   = 0;
    cycle_cnt  = 0;
    repeat (4) @(posedge clk);
    #(drive_dly);
    reset_n = 1'b1;
    compare_bit("ack after reset", ack, 1'b0);
    compare_bit("lock after reset", lock, 1'b0);
    compare_code("dll_code after reset", dll_code, dll_code_t'(0));
    register_access();
    filter_rejects_noise(2);
    half_code_output(4);
    acquire_and_disable(6);
    saturate_code();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+tb
common/dll_code_pkg.sv
common/dll_csr_pkg.sv
dll_ctrl/dll_phase_filter.sv
dll_ctrl/dll_lock_fsm.sv
logic/half_cycle_code_gen.sv
logic/dll_csr_wb.sv
logic/dll_code_top.sv
tb/dll_code_tb.sv

/* Makefile */
# Verilator build of dll_code_tb; run fails when the testbench stops with $fatal

SRCS := $(shell grep -v '^+' filelist.f) tb/dll_code_model.svh

obj_dir/dll_code_sim: $(SRCS) filelist.f
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module dll_code_tb -o dll_code_sim

run: obj_dir/dll_code_sim
	./obj_dir/dll_code_sim

clean:
	rm -rf obj_dir

.PHONY: run clean
